//--- multicycleController.f
+incdir+.
rvCtrlPkg.sv
mainFsm.sv
instrDecoder.sv
multicycleController.sv
rvCtrl_props.sv
tb_multicycleController.sv

//--- run.sh
#!/bin/sh
# Builds and runs the controller testbench with Verilator.
# The run passes only when the log holds the pass line.
set -e
cd "$(dirname "$0")"
verilator --binary --assert --top-module tb_multicycleController \
    -f multicycleController.f -o simTb
./obj_dir/simTb | tee sim.log
grep -qx "No errors" sim.log

//--- tb_multicycleController.sv
/*
 * Directed testbench for the multicycle controller. Runs each instruction
 * class through its state path and checks the control bus every cycle.
 */
`timescale 1ns/1ns
`include "rvCtrl_cfg.svh"

module tb_multicycleController;

    import rvCtrlPkg::*;

    localparam int CLK_NS       = 4;
    localparam int RESET_CYCLES = 10;
    localparam int TEST_CYCLES  = 108;  // cycles per instruction summed over all tests

    logic                 clk;
    logic                 resetn;
    logic [`OPCODE_W-1:0] op;
    logic [`FUNCT3_W-1:0] funct3;
    logic                 funct7b5;
    logic                 zero;
    ctrlBus_t             ctrl;
    logic                 illegal;
    int                   errors;
    int                   checks;

    multicycleController u_multicycleController (
        .clk        (clk),
        .resetn     (resetn),
        .i_op       (op),
        .i_funct3   (funct3),
        .i_funct7b5 (funct7b5),
        .i_zero     (zero),
        .o_ctrl     (ctrl),
        .o_illegal  (illegal)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    initial
    begin
        #((2 * TEST_CYCLES + RESET_CYCLES) * CLK_NS);
        $display("watchdog expired before the tests finished, %0d errors so far", errors);
        $display("Errors found");
        $finish;
    end

    // expected bus for a state, given the current IR fields
    function automatic ctrlBus_t expectCtrl(state_t s, aluCtrl_t execAlu);
        ctrlBus_t c;
        c = '0;
        case (s)
            S_FETCH:    {c.pcWrite, c.irWrite, c.resultSrc, c.aluSrcB} = 6'b111010;
            S_DECODE:   {c.aluSrcA, c.aluSrcB} = 4'b0101;
            S_MEMADDR,
            S_EXECI:    {c.aluSrcA, c.aluSrcB} = 4'b1001;
            S_MEMREAD:  c.adrSrc = 1'b1;
            S_MEMWB:    {c.resultSrc, c.regWrite} = 3'b011;
            S_MEMWRITE: {c.adrSrc, c.memWrite} = 2'b11;
            S_EXECR:    c.aluSrcA = 2'b10;
            S_ALUWB:    c.regWrite = 1'b1;
            S_JAL:      {c.pcWrite, c.aluSrcA, c.aluSrcB} = 5'b10110;
            S_BEQ:      {c.pcWrite, c.aluSrcA, c.aluSrcB} = {zero, 4'b1000};
            S_LUI:      {c.aluSrcA, c.aluSrcB} = 4'b1110;
            default:    c = '0;  // reset and error idle
        endcase
        if (s == S_BEQ)
            c.aluControl = ALU_SUB;
        else if (s == S_EXECR || s == S_EXECI)
            c.aluControl = execAlu;  // code given by the test for this funct
        case (op)
            `OP_STORE:  c.immSrc = IMM_S;
            `OP_BRANCH: c.immSrc = IMM_B;
            `OP_JAL:    c.immSrc = IMM_J;
            `OP_LUI:    c.immSrc = IMM_U;
            default:    c.immSrc = IMM_I;
        endcase
        return c;
    endfunction

    // state sequence per opcode, tail padded with the next Fetch
    function automatic state_t pathState(logic [`OPCODE_W-1:0] opcode, logic [2:0] idx);
        state_t p [0:5];
        case (opcode)
            `OP_LOAD:   p = '{S_FETCH, S_DECODE, S_MEMADDR, S_MEMREAD, S_MEMWB, S_FETCH};
            `OP_STORE:  p = '{S_FETCH, S_DECODE, S_MEMADDR, S_MEMWRITE, S_FETCH, S_FETCH};
            `OP_RTYPE:  p = '{S_FETCH, S_DECODE, S_EXECR, S_ALUWB, S_FETCH, S_FETCH};
            `OP_ITYPE:  p = '{S_FETCH, S_DECODE, S_EXECI, S_ALUWB, S_FETCH, S_FETCH};
            `OP_JAL:    p = '{S_FETCH, S_DECODE, S_JAL, S_ALUWB, S_FETCH, S_FETCH};
            `OP_BRANCH: p = '{S_FETCH, S_DECODE, S_BEQ, S_FETCH, S_FETCH, S_FETCH};
            `OP_LUI:    p = '{S_FETCH, S_DECODE, S_LUI, S_EXECI, S_ALUWB, S_FETCH};
            `OP_NOP:    p = '{S_FETCH, S_DECODE, S_FETCH, S_FETCH, S_FETCH, S_FETCH};
            default:    p = '{S_FETCH, S_DECODE, S_ERROR, S_RESET, S_FETCH, S_FETCH};
        endcase
        return p[idx];
    endfunction

    task automatic checkState(state_t s, aluCtrl_t execAlu);
        ctrlBus_t expCtrl;
        logic     expIllegal;
        expCtrl = expectCtrl(s, execAlu);
        expIllegal = (s == S_ERROR);  // strobe only in the error state
        checks++;
        if (ctrl !== expCtrl)
        begin
            errors++;
            $display("FAIL %0t ns o_ctrl in %s: expected %h, got %h",
                     $time, s.name(), expCtrl, ctrl);
        end
        if (illegal !== expIllegal)
        begin
            errors++;
            $display("FAIL %0t ns o_illegal in %s: expected %b, got %b",
                     $time, s.name(), expIllegal, illegal);
        end
    endtask

    task automatic runInstr(logic [`OPCODE_W-1:0] opcode, logic [2:0] f3, logic f7b5,
                            logic z, aluCtrl_t execAlu);
        int         waited;
        logic [2:0] idx;
        waited = 0;
        @(negedge clk);
        while (!ctrl.irWrite && waited < 8)
        begin
            @(negedge clk);
            waited++;
        end
        if (waited != 0)
        begin
            errors++;
            $display("Fetch came %0d cycles late before opcode %b", waited, opcode);
        end
        op = opcode;  // IR loads at the end of Fetch
        funct3 = f3;
        funct7b5 = f7b5;
        zero = z;
        idx = 3'd0;
        while (idx == 3'd0 || pathState(opcode, idx) != S_FETCH)
        begin
            if (idx != 3'd0)
                @(negedge clk);
            #1;  // settle after the falling-edge drive
            checkState(pathState(opcode, idx), execAlu);
            idx++;
        end
    endtask

    task automatic resetTest;
        repeat (RESET_CYCLES) @(negedge clk);
        resetn = 1'b0;
        #1;
        checkState(S_RESET, ALU_ADD);
    endtask

    task automatic memTest;
        runInstr(`OP_LOAD, 3'b010, 1'b0, 1'b0, ALU_ADD);
        runInstr(`OP_STORE, 3'b010, 1'b0, 1'b0, ALU_ADD);
    endtask

    task automatic aluTest;
        // ALU code per funct3 when funct7b5 is clear
        aluCtrl_t f3Alu [0:7];
        f3Alu = '{ALU_ADD, ALU_ADD, ALU_SLT, ALU_ADD, ALU_XOR, ALU_ADD, ALU_OR, ALU_AND};
        for (int f = 0; f < 8; f++)
            runInstr(`OP_RTYPE, 3'(f), 1'b0, 1'b0, f3Alu[f]);
        runInstr(`OP_RTYPE, 3'b000, 1'b1, 1'b0, ALU_SUB);  // sub
        for (int f = 0; f < 8; f++)
            runInstr(`OP_ITYPE, 3'(f), 1'b0, 1'b0, f3Alu[f]);
        runInstr(`OP_ITYPE, 3'b000, 1'b1, 1'b0, ALU_ADD);  // addi ignores funct7b5
    endtask

    task automatic branchJumpTest;
        runInstr(`OP_BRANCH, 3'b000, 1'b0, 1'b0, ALU_ADD);
        runInstr(`OP_BRANCH, 3'b000, 1'b0, 1'b1, ALU_ADD);
        runInstr(`OP_JAL, 3'b000, 1'b0, 1'b0, ALU_ADD);
    endtask

    task automatic luiNopTest;
        runInstr(`OP_LUI, 3'b000, 1'b0, 1'b0, ALU_ADD);
        runInstr(`OP_NOP, 3'b000, 1'b0, 1'b0, ALU_ADD);
    endtask

    task automatic illegalTest;
        runInstr(7'b1111111, 3'b000, 1'b0, 1'b0, ALU_ADD);
        runInstr(7'b0010111, 3'b000, 1'b0, 1'b0, ALU_ADD);  // auipc is not supported
        runInstr(`OP_NOP, 3'b000, 1'b0, 1'b0, ALU_ADD);     // Fetch must follow Reset
    endtask

    initial
    begin
        resetn = 1'b1;
        op = `OP_NOP;
        funct3 = '0;
        funct7b5 = 1'b0;
        zero = 1'b0;
        errors = 0;
        checks = 0;
        resetTest();
        memTest();
        aluTest();
        branchJumpTest();
        luiNopTest();
        illegalTest();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

//--- rvCtrl_props.sv
/*
 * Concurrent checks on the controller's output bus. Bound into the
 * controller top, so every instance is covered without editing the RTL.
 */
`timescale 1ns/1ns

module rvCtrl_props (
    input logic                clk,
    input logic                resetn,
    input rvCtrlPkg::ctrlBus_t i_ctrl,
    input logic                i_illegal
);

    // memory and register file never written in one cycle
    a_noDualWrite: assert property (@(posedge clk) disable iff (resetn)
        !(i_ctrl.memWrite && i_ctrl.regWrite))
        else $error("memWrite and regWrite high in the same cycle");

    a_illegalStrobe: assert property (@(posedge clk) disable iff (resetn)
        i_illegal |=> !i_illegal)
        else $error("o_illegal held for more than one cycle");

    // Fetch is always followed by Decode
    a_irWriteGap: assert property (@(posedge clk) disable iff (resetn)
        i_ctrl.irWrite |=> !i_ctrl.irWrite)
        else $error("irWrite high on two cycles in a row");

endmodule

bind multicycleController rvCtrl_props u_rvCtrlProps (
    .clk       (clk),
    .resetn    (resetn),
    .i_ctrl    (o_ctrl),
    .i_illegal (o_illegal)
);

//--- multicycleController.sv
/*
 * Top of the multicycle RV32 control unit. Joins the FSM and the ALU /
 * immediate decoder into one control bus for the datapath.
 */
`timescale 1ns/1ns
`include "rvCtrl_cfg.svh"

module multicycleController (
    input  logic                 clk,
    input  logic                 resetn,
    input  logic [`OPCODE_W-1:0] i_op,        // from the instruction register
    input  logic [`FUNCT3_W-1:0] i_funct3,
    input  logic                 i_funct7b5,
    input  logic                 i_zero,
    output rvCtrlPkg::ctrlBus_t  o_ctrl,
    output logic                 o_illegal    // one-cycle strobe from S_ERROR
);

    import rvCtrlPkg::*;

    fsmCtrl_t fsmCtrl;
    aluCtrl_t aluControl;
    immSrc_t  immSrc;

    mainFsm u_mainFsm (
        .clk       (clk),
        .resetn    (resetn),
        .i_op      (i_op),
        .i_zero    (i_zero),
        .o_fsmCtrl (fsmCtrl),
        .o_illegal (o_illegal)
    );

    instrDecoder u_instrDecoder (
        .i_aluOp      (fsmCtrl.aluOp),
        .i_op         (i_op),
        .i_funct3     (i_funct3),
        .i_funct7b5   (i_funct7b5),
        .o_aluControl (aluControl),
        .o_immSrc     (immSrc)
    );

    // aluOp stays internal, replaced by the decoded code
    assign o_ctrl = '{
        pcWrite:    fsmCtrl.pcWrite,
        adrSrc:     fsmCtrl.adrSrc,
        memWrite:   fsmCtrl.memWrite,
        irWrite:    fsmCtrl.irWrite,
        resultSrc:  fsmCtrl.resultSrc,
        aluSrcA:    fsmCtrl.aluSrcA,
        aluSrcB:    fsmCtrl.aluSrcB,
        regWrite:   fsmCtrl.regWrite,
        aluControl: aluControl,
        immSrc:     immSrc
    };

endmodule

//--- instrDecoder.sv
/*
 * Combinational decoder: turns the FSM's ALU operation class into an ALU
 * control code and picks the immediate type from the opcode.
 */
`timescale 1ns/1ns
`include "rvCtrl_cfg.svh"

module instrDecoder (
    input  rvCtrlPkg::aluOp_t    i_aluOp,
    input  logic [`OPCODE_W-1:0] i_op,
    input  logic [`FUNCT3_W-1:0] i_funct3,
    input  logic                 i_funct7b5,
    output rvCtrlPkg::aluCtrl_t  o_aluControl,
    output rvCtrlPkg::immSrc_t   o_immSrc
);

    import rvCtrlPkg::*;

    logic rTypeSub;

    // only R-type uses funct7b5 for sub; addi has no such bit
    assign rTypeSub = (i_op == `OP_RTYPE) && i_funct7b5;

    always_comb
    begin
        o_aluControl = ALU_ADD;
        case (i_aluOp)
            ALUOP_ADD:  o_aluControl = ALU_ADD;
            ALUOP_SUB:  o_aluControl = ALU_SUB;
            ALUOP_FUNCT:
            begin
                case (i_funct3)
                    3'b000:  o_aluControl = rTypeSub ? ALU_SUB : ALU_ADD;
                    3'b010:  o_aluControl = ALU_SLT;
                    3'b100:  o_aluControl = ALU_XOR;
                    3'b110:  o_aluControl = ALU_OR;
                    3'b111:  o_aluControl = ALU_AND;
                    default: o_aluControl = ALU_ADD;  // shifts / sltu not supported
                endcase
            end
            default:    o_aluControl = ALU_ADD;
        endcase
    end

    // immediate layout by instruction format
    always_comb
    begin
        case (i_op)
            `OP_STORE:  o_immSrc = IMM_S;
            `OP_BRANCH: o_immSrc = IMM_B;
            `OP_JAL:    o_immSrc = IMM_J;
            `OP_LUI:    o_immSrc = IMM_U;
            default:    o_immSrc = IMM_I;
        endcase
    end

endmodule

//--- mainFsm.sv
/*
 * Moore FSM of the multicycle controller. Steps one instruction at a time
 * through fetch, decode and execute, driving the per-state control bundle.
 * The opcode input must hold from Decode until the instruction finishes.
 */
`timescale 1ns/1ns
`include "rvCtrl_cfg.svh"

module mainFsm (
    input  logic                 clk,
    input  logic                 resetn,      // high puts the FSM back in S_RESET
    input  logic [`OPCODE_W-1:0] i_op,
    input  logic                 i_zero,      // ALU zero flag, used by beq only
    output rvCtrlPkg::fsmCtrl_t  o_fsmCtrl,
    output logic                 o_illegal
);

    import rvCtrlPkg::*;

    state_t state;
    state_t nextState;

    always_ff @(posedge clk)
    begin
        if (resetn)
        begin
            state <= S_RESET;
        end
        else
        begin
            state <= nextState;
        end
    end

    // next state from current state and opcode
    always_comb
    begin
        nextState = S_ERROR;
        case (state)
            S_RESET:    nextState = S_FETCH;
            S_FETCH:    nextState = S_DECODE;
            S_DECODE:
            begin
                case (i_op)
                    `OP_LOAD,
                    `OP_STORE:  nextState = S_MEMADDR;
                    `OP_RTYPE:  nextState = S_EXECR;
                    `OP_ITYPE:  nextState = S_EXECI;
                    `OP_JAL:    nextState = S_JAL;
                    `OP_BRANCH: nextState = S_BEQ;
                    `OP_LUI:    nextState = S_LUI;
                    `OP_NOP:    nextState = S_FETCH;  // nothing to execute
                    default:    nextState = S_ERROR;
                endcase
            end
            S_MEMADDR:
            begin
                if (i_op == `OP_LOAD)
                begin
                    nextState = S_MEMREAD;
                end
                else if (i_op == `OP_STORE)
                begin
                    nextState = S_MEMWRITE;
                end
                else
                begin
                    nextState = S_ERROR;  // opcode changed mid-instruction
                end
            end
            S_MEMREAD:  nextState = S_MEMWB;
            S_EXECR,
            S_EXECI,
            S_JAL:      nextState = S_ALUWB;
            S_LUI:      nextState = S_EXECI;  // upper imm added to zero base
            S_MEMWB,
            S_MEMWRITE,
            S_ALUWB,
            S_BEQ:      nextState = S_FETCH;
            S_ERROR:    nextState = S_RESET;
            default:    nextState = S_ERROR;
        endcase
    end

    // controls depend on state only, apart from the beq pcWrite
    always_comb
    begin
        o_fsmCtrl = '0;
        o_fsmCtrl.aluOp = ALUOP_ADD;
        case (state)
            S_FETCH:
            begin
                o_fsmCtrl.pcWrite   = 1'b1;
                o_fsmCtrl.irWrite   = 1'b1;
                o_fsmCtrl.resultSrc = 2'b10;  // PC + 4 straight from the ALU
                o_fsmCtrl.aluSrcA   = 2'b00;
                o_fsmCtrl.aluSrcB   = 2'b10;
            end
            S_DECODE:
            begin
                // branch / jump target precomputed here
                o_fsmCtrl.aluSrcA = 2'b01;
                o_fsmCtrl.aluSrcB = 2'b01;
            end
            S_MEMADDR:
            begin
                o_fsmCtrl.aluSrcA = 2'b10;
                o_fsmCtrl.aluSrcB = 2'b01;
            end
            S_MEMREAD:  o_fsmCtrl.adrSrc = 1'b1;
            S_MEMWB:
            begin
                o_fsmCtrl.resultSrc = 2'b01;  // read data
                o_fsmCtrl.regWrite  = 1'b1;
            end
            S_MEMWRITE:
            begin
                o_fsmCtrl.adrSrc   = 1'b1;
                o_fsmCtrl.memWrite = 1'b1;
            end
            S_EXECR:
            begin
                o_fsmCtrl.aluSrcA = 2'b10;
                o_fsmCtrl.aluSrcB = 2'b00;
                o_fsmCtrl.aluOp   = ALUOP_FUNCT;
            end
            S_ALUWB:    o_fsmCtrl.regWrite = 1'b1;
            S_EXECI:
            begin
                o_fsmCtrl.aluSrcA = 2'b10;
                o_fsmCtrl.aluSrcB = 2'b01;
                o_fsmCtrl.aluOp   = ALUOP_FUNCT;
            end
            S_JAL:
            begin
                o_fsmCtrl.pcWrite = 1'b1;
                o_fsmCtrl.aluSrcA = 2'b01;  // old PC + 4 for rd
                o_fsmCtrl.aluSrcB = 2'b10;
            end
            S_BEQ:
            begin
                o_fsmCtrl.pcWrite = i_zero;  // taken only when rs1 == rs2
                o_fsmCtrl.aluSrcA = 2'b10;
                o_fsmCtrl.aluSrcB = 2'b00;
                o_fsmCtrl.aluOp   = ALUOP_SUB;
            end
            S_LUI:
            begin
                o_fsmCtrl.aluSrcA = 2'b11;  // zero operand
                o_fsmCtrl.aluSrcB = 2'b10;
            end
            default:    o_fsmCtrl = '0;  // reset and error stay idle
        endcase
    end

    assign o_illegal = (state == S_ERROR);

endmodule

//--- rvCtrlPkg.sv
/*
 * Types shared by the controller blocks and the testbench: FSM states,
 * ALU operation classes, ALU control codes, immediate types and the buses.
 */
`include "rvCtrl_cfg.svh"

package rvCtrlPkg;

    typedef enum logic [3:0] {
        S_RESET, S_FETCH, S_DECODE, S_MEMADDR, S_MEMREAD, S_MEMWB, S_MEMWRITE,
        S_EXECR, S_ALUWB, S_EXECI, S_JAL, S_BEQ, S_LUI, S_ERROR
    } state_t;

    // operation class issued by the FSM
    typedef enum logic [1:0] {
        ALUOP_ADD   = 2'b00,
        ALUOP_SUB   = 2'b01,
        ALUOP_FUNCT = 2'b10  // decode from funct3 / funct7b5
    } aluOp_t;

    typedef enum logic [`ALUCTRL_W-1:0] {
        ALU_ADD = 3'b000,
        ALU_SUB = 3'b001,
        ALU_AND = 3'b010,
        ALU_OR  = 3'b011,
        ALU_XOR = 3'b100,
        ALU_SLT = 3'b101
    } aluCtrl_t;

    typedef enum logic [`IMMSRC_W-1:0] {
        IMM_I = 3'b000,
        IMM_S = 3'b001,
        IMM_B = 3'b010,
        IMM_J = 3'b011,
        IMM_U = 3'b100
    } immSrc_t;

    // per-state controls straight out of the FSM
    typedef struct packed {
        logic              pcWrite;
        logic              adrSrc;
        logic              memWrite;
        logic              irWrite;
        logic [`SEL_W-1:0] resultSrc;
        logic [`SEL_W-1:0] aluSrcA;
        logic [`SEL_W-1:0] aluSrcB;
        logic              regWrite;
        aluOp_t            aluOp;
    } fsmCtrl_t;

    // full bundle seen by the datapath
    typedef struct packed {
        logic              pcWrite;
        logic              adrSrc;
        logic              memWrite;
        logic              irWrite;
        logic [`SEL_W-1:0] resultSrc;
        logic [`SEL_W-1:0] aluSrcA;
        logic [`SEL_W-1:0] aluSrcB;
        logic              regWrite;
        aluCtrl_t          aluControl;
        immSrc_t           immSrc;
    } ctrlBus_t;

endpackage

//--- rvCtrl_cfg.svh
/*
 * Shared widths and RV32 opcode values for the multicycle control unit.
 * Include this header wherever port widths or opcode compares are needed.
 */
`ifndef RVCTRL_CFG_SVH
`define RVCTRL_CFG_SVH

// instruction field widths
`define OPCODE_W  7
`define FUNCT3_W  3

// datapath select and code widths
`define SEL_W     2
`define ALUCTRL_W 3
`define IMMSRC_W  3

// major opcodes, bits [6:0] of the instruction
`define OP_LOAD   7'b0000011
`define OP_STORE  7'b0100011
`define OP_RTYPE  7'b0110011
`define OP_ITYPE  7'b0010011
`define OP_JAL    7'b1101111
`define OP_BRANCH 7'b1100011
`define OP_LUI    7'b0110111
`define OP_NOP    7'b0000000  // all-zero word treated as nop

`endif
